// ==== tb.f ====
rtl/sms_pkg.sv
rtl/sms_ram_if.sv
rtl/sms_ahb_if.sv
rtl/sms_region_guard.sv
rtl/sms_ahb_slave.sv
rtl/sms_sram_bank.sv
rtl/sms_bank_top.sv
tb/tb_clk_gen.sv
tb/tb_sms_bank.sv

// ==== Bender.yml ====
package:
  name: sms_bank

sources:
  - rtl/sms_pkg.sv
  - rtl/sms_ram_if.sv
  - rtl/sms_ahb_if.sv
  - rtl/sms_region_guard.sv
  - rtl/sms_ahb_slave.sv
  - rtl/sms_sram_bank.sv
  - rtl/sms_bank_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_sms_bank.sv

// ==== tb/tb_sms_bank.sv ====
// Table-driven regression for the AHB SRAM bank. Each entry runs one AHB
// transfer and is checked against a byte-wide reference memory.

`timescale 1ns/1ps

module tb_sms_bank;

  localparam logic [1:0] OP_WR = 2'd0;
  localparam logic [1:0] OP_RD = 2'd1;
  localparam logic [1:0] OP_RAW = 2'd2;  // Write, then read right behind it
  localparam logic LE = 1'b1;
  localparam logic BE = 1'b0;
  localparam int NUM_TESTS = 17;

  typedef struct packed {
    logic [1:0]      op;
    sms_pkg::hsize_t size;
    logic [15:0]     addr;
    logic            endian_b;
    logic            deny;
  } entry_t;

  entry_t stim [NUM_TESTS] = '{
    '{OP_WR,  sms_pkg::SIZE_WORD, 16'h0000, LE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_WORD, 16'h0004, LE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_WORD, 16'h0100, LE, 1'b0},
    '{OP_RD,  sms_pkg::SIZE_WORD, 16'h0000, LE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_BYTE, 16'h0005, LE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_HALF, 16'h0006, LE, 1'b0},
    '{OP_RD,  sms_pkg::SIZE_WORD, 16'h0004, LE, 1'b0},
    '{OP_RAW, sms_pkg::SIZE_WORD, 16'h0008, LE, 1'b0},
    '{OP_RAW, sms_pkg::SIZE_BYTE, 16'h0101, LE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_BYTE, 16'h0102, BE, 1'b0},
    '{OP_RD,  sms_pkg::SIZE_BYTE, 16'h0102, BE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_HALF, 16'h0000, BE, 1'b0},
    '{OP_RD,  sms_pkg::SIZE_HALF, 16'h0002, BE, 1'b0},
    '{OP_WR,  sms_pkg::SIZE_WORD, 16'h0004, LE, 1'b1},
    '{OP_RD,  sms_pkg::SIZE_WORD, 16'h0004, LE, 1'b0},
    '{OP_RD,  sms_pkg::SIZE_WORD, 16'h0100, LE, 1'b1},
    '{OP_RD,  sms_pkg::SIZE_HALF, 16'h0000, BE, 1'b0}
  };

  logic clk, rst_b, hsel, hwrite, big_endian_b, rd_deny, wr_deny;
  logic o_hready, o_idle;
  logic [31:0] haddr, hwdata, o_hrdata;
  sms_pkg::htrans_t htrans;
  sms_pkg::hsize_t  hsize;
  sms_pkg::hresp_t  o_hresp;
  logic [7:0]  ref_mem [65536];
  logic [15:0] lfsr = 16'd44390;
  int test_errs, total_errs, failed_tests;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_b(rst_b));

  sms_bank_top sms_bank_top_i (
    .i_sys_hclk(clk), .i_sys_rst_b(rst_b), .i_hsel(hsel), .i_haddr(haddr),
    .i_htrans(htrans), .i_hsize(hsize), .i_hwrite(hwrite), .i_hwdata(hwdata),
    .i_big_endian_b(big_endian_b), .i_rd_deny(rd_deny), .i_wr_deny(wr_deny),
    .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp), .o_idle(o_idle)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  // Big-endian masters see byte k of an n-byte access on lane 4-n-off+k
  function automatic int first_lane(input logic [15:0] a, input int n, input logic le);
    return le ? int'(a[1:0]) : 4 - n - int'(a[1:0]);
  endfunction

  task automatic model_write(input entry_t e, input logic [31:0] d);
    int n;
    int lane0;
    n     = 1 << e.size;
    lane0 = first_lane(e.addr, n, e.endian_b);
    for (int k = 0; k < n; k++)
      ref_mem[int'(e.addr) + k] = d[(lane0 + k)*8 +: 8];
  endtask

  // Little-endian reads return the whole word and big-endian reads only the lanes used
  function automatic logic [31:0] model_read(input entry_t e);
    logic [31:0] r;
    int n;
    int lane0;
    int base;
    r    = '0;
    n    = e.endian_b ? 4 : (1 << e.size);
    base = e.endian_b ? int'({e.addr[15:2], 2'b00}) : int'(e.addr);
    lane0 = e.endian_b ? 0 : first_lane(e.addr, n, 1'b0);
    for (int k = 0; k < n; k++)
      r[(lane0 + k)*8 +: 8] = ref_mem[base + k];
    return r;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic go_idle();
    hsel    <= 1'b0;
    htrans  <= 2'b00;
    hwrite  <= 1'b0;
    rd_deny <= 1'b0;
    wr_deny <= 1'b0;
  endtask

  // Count low-ready data phase cycles and keep the first and the final response
  task automatic wait_phase(output int waits, output sms_pkg::hresp_t first_resp,
                            output sms_pkg::hresp_t last_resp, output logic [31:0] rdata);
    waits = 0;
    @(negedge clk);
    first_resp = o_hresp;
    while (!o_hready)
    begin
      waits++;
      @(negedge clk);
    end
    last_resp = o_hresp;
    rdata     = o_hrdata;
  endtask

  task automatic run_entry(input int idx);
    entry_t          e;
    logic [31:0]     wdata;
    logic [31:0]     rdata;
    int              waits;
    sms_pkg::hresp_t first_resp;
    sms_pkg::hresp_t last_resp;
    e         = stim[idx];
    test_errs = 0;
    next_word(wdata);
    @(posedge clk);
    @(negedge clk);
    check_val("o_idle between transfers", o_idle, 1'b1);
    @(posedge clk);
    hsel         <= 1'b1;
    htrans       <= sms_pkg::TRANS_NONSEQ;
    haddr        <= {16'h0000, e.addr};
    hsize        <= e.size;
    hwrite       <= (e.op != OP_RD);
    big_endian_b <= e.endian_b;
    rd_deny      <= e.deny && (e.op == OP_RD);
    wr_deny      <= e.deny && (e.op != OP_RD);
    @(negedge clk);
    check_val("o_hready in address phase", o_hready, 1'b1);
    if (!e.deny)
      check_val("o_idle in address phase", o_idle, 1'b0);
    @(posedge clk);
    hwdata <= wdata;
    if (e.op == OP_RAW)
      hwrite <= 1'b0;
    else
      go_idle();
    wait_phase(waits, first_resp, last_resp, rdata);
    if (e.deny)
    begin
      check_val("wait states on denied transfer", waits, 1);
      check_val("first response on denied transfer", first_resp, sms_pkg::RESP_ERROR);
      check_val("final response on denied transfer", last_resp, sms_pkg::RESP_ERROR);
    end
    else
    begin
      check_val("wait states", waits, 0);
      check_val("response", last_resp, sms_pkg::RESP_OKAY);
      if (e.op == OP_RD)
        check_val("read data", rdata, model_read(e));
      else
        model_write(e, wdata);
    end
    if (e.op == OP_RAW)
    begin
      @(posedge clk);
      go_idle();
      wait_phase(waits, first_resp, last_resp, rdata);
      check_val("wait states of read after write", waits, 1);
      check_val("response of read after write", last_resp, sms_pkg::RESP_OKAY);
      check_val("read after write data", rdata, model_read(e));
    end
    if (test_errs != 0)
      failed_tests++;
    $display("test %0d op %0d size %0d addr %h: %s", idx, e.op, e.size, e.addr,
             (test_errs == 0) ? "ok" : "FAILED");
  endtask

  initial
  begin
    total_errs   = 0;
    failed_tests = 0;
    hsel         = 1'b0;
    haddr        = '0;
    htrans       = 2'b00;
    hsize        = sms_pkg::SIZE_WORD;
    hwrite       = 1'b0;
    hwdata       = '0;
    big_endian_b = LE;
    rd_deny      = 1'b0;
    wr_deny      = 1'b0;
    @(posedge rst_b);
    @(negedge clk);
    check_val("o_hready after reset", o_hready, 1'b1);
    check_val("o_hresp after reset", o_hresp, sms_pkg::RESP_OKAY);
    check_val("o_idle after reset", o_idle, 1'b1);
    for (int i = 0; i < NUM_TESTS; i++)
      run_entry(i);
    $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, NUM_TESTS - failed_tests,
             failed_tests);
    if (total_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // Reset plus at most 20 cycles per table entry
  initial
  begin
    #((16 + NUM_TESTS * 20) * 10);
    $display("Timeout: the DUT stopped answering before all tests finished");
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
// Clock and reset source for the SRAM bank testbench.
// 10 ns clock, reset held low for the first 16 rising edges.

`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_b
);

  initial
  begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial
  begin
    o_rst_b = 1'b0;
    repeat (16) @(posedge o_clk);
    o_rst_b <= 1'b1;
  end

endmodule

// ==== rtl/sms_bank_top.sv ====
// 64 KiB AHB-Lite SRAM bank. Region guard, AHB slave and RAM behind plain
// AHB ports; only the low bank offset bits of the address are decoded.

`timescale 1ns/1ps

module sms_bank_top (
  input  logic                       i_sys_hclk,
  input  logic                       i_sys_rst_b,
  input  logic                       i_hsel,
  input  logic [31:0]                i_haddr,
  input  sms_pkg::htrans_t           i_htrans,
  input  sms_pkg::hsize_t            i_hsize,
  input  logic                       i_hwrite,
  input  logic [sms_pkg::DATA_W-1:0] i_hwdata,
  input  logic                       i_big_endian_b,
  input  logic                       i_rd_deny,
  input  logic                       i_wr_deny,
  output logic [sms_pkg::DATA_W-1:0] o_hrdata,
  output logic                       o_hready,
  output sms_pkg::hresp_t            o_hresp,
  output logic                       o_idle
);

  sms_ahb_if ahb_bus ();
  sms_ram_if ram_bus ();

  sms_region_guard u_region_guard (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_hsel      (i_hsel),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_rd_deny   (i_rd_deny),
    .i_wr_deny   (i_wr_deny),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .bus         (ahb_bus.guard)
  );

  sms_ahb_slave u_ahb_slave (
    .i_sys_hclk     (i_sys_hclk),
    .i_sys_rst_b    (i_sys_rst_b),
    .i_haddr        (i_haddr[sms_pkg::ADDR_W-1:0]),
    .i_hsize        (i_hsize),
    .i_hwrite       (i_hwrite),
    .i_hwdata       (i_hwdata),
    .i_big_endian_b (i_big_endian_b),
    .o_hrdata       (o_hrdata),
    .o_idle         (o_idle),
    .bus            (ahb_bus.slave),
    .ram            (ram_bus.master)
  );

  sms_sram_bank u_sram_bank (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .ram         (ram_bus.ram)
  );

endmodule

// ==== rtl/sms_sram_bank.sv ====
// Single-port byte-enabled SRAM bank with a registered read port.
// Read data is forced to zero after a cycle without a request.

`timescale 1ns/1ps

module sms_sram_bank (
  input  logic    i_sys_hclk,
  input  logic    i_sys_rst_b,
  sms_ram_if.ram  ram
);

  sms_pkg::lane_mask_t              lane_sel;
  sms_pkg::lane_mask_t              byte_we;
  logic [sms_pkg::WORD_ADDR_W-1:0]  word_addr;
  logic [sms_pkg::DATA_W-1:0]       mem [sms_pkg::RAM_DEPTH];
  logic [sms_pkg::DATA_W-1:0]       rdata_q;
  logic                             sel_q;

  always_comb
  begin
    case (ram.size)
      sms_pkg::SIZE_BYTE: lane_sel = sms_pkg::lane_mask_t'(1) << ram.addr[1:0];
      sms_pkg::SIZE_HALF: lane_sel = ram.addr[1] ? 4'b1100 : 4'b0011;
      sms_pkg::SIZE_WORD: lane_sel = '1;
      default:            lane_sel = '0;
    endcase
  end

  assign byte_we   = lane_sel & {sms_pkg::BYTES_W{ram.sel && ram.write}};
  assign word_addr = ram.addr[sms_pkg::ADDR_W-1:2];

  always_ff @(posedge i_sys_hclk)
  begin
    if (ram.sel)
    begin
      for (int i = 0; i < sms_pkg::BYTES_W; i++)
      begin
        if (byte_we[i])
          mem[word_addr][i*8 +: 8] <= ram.wdata[i*8 +: 8];
      end
      rdata_q <= mem[word_addr];  // Old contents on a write
    end
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      sel_q <= 1'b0;
    else
      sel_q <= ram.sel;
  end

  assign ram.rdata = sel_q ? rdata_q : '0;

  a_half_aligned : assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    (ram.sel && ram.size == sms_pkg::SIZE_HALF) |-> !ram.addr[0]
  );

endmodule

// ==== rtl/sms_ahb_slave.sv ====
// AHB-Lite slave side of the bank. Tracks the data phase, delays writes by
// one cycle, stalls a read that follows a write and maps byte lanes for
// big-endian masters before requests reach the RAM.

`timescale 1ns/1ps

module sms_ahb_slave (
  input  logic                       i_sys_hclk,
  input  logic                       i_sys_rst_b,
  input  logic [sms_pkg::ADDR_W-1:0] i_haddr,
  input  sms_pkg::hsize_t            i_hsize,
  input  logic                       i_hwrite,
  input  logic [sms_pkg::DATA_W-1:0] i_hwdata,
  input  logic                       i_big_endian_b,
  output logic [sms_pkg::DATA_W-1:0] o_hrdata,
  output logic                       o_idle,
  sms_ahb_if.slave                   bus,
  sms_ram_if.master                  ram
);

  logic                       act;
  logic                       rd_now;
  logic                       dp_sel;
  logic                       dp_write;
  logic [sms_pkg::ADDR_W-1:0] dp_addr;
  sms_pkg::hsize_t            dp_size;
  logic                       wr_pend;
  logic                       raw_flag;
  logic                       use_dp;
  logic [1:0]                 off;

  assign act = bus.sel && bus.ready &&
               (bus.trans == sms_pkg::TRANS_NONSEQ || bus.trans == sms_pkg::TRANS_SEQ);
  assign rd_now  = act && !i_hwrite;
  assign wr_pend = dp_sel && dp_write;  // Write waiting for its data phase

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      dp_sel   <= 1'b0;
      dp_write <= 1'b0;
      raw_flag <= 1'b0;
    end
    else
    begin
      if (bus.ready)
        dp_sel <= act;
      if (act)
        dp_write <= i_hwrite;
      raw_flag <= wr_pend && rd_now;  // Read loses the RAM to the write
    end
  end

  // Address phase payload, also the hold entry for a delayed write
  always_ff @(posedge i_sys_hclk)
  begin
    if (act)
    begin
      dp_addr <= i_haddr;
      dp_size <= i_hsize;
    end
  end

  assign bus.ready = !raw_flag;
  assign bus.resp  = sms_pkg::RESP_OKAY;

  // Pending write first, then the held read, then a fresh read
  assign use_dp    = wr_pend || raw_flag;
  assign ram.sel   = use_dp || rd_now;
  assign ram.write = wr_pend;
  assign ram.addr  = use_dp ? dp_addr : i_haddr;
  assign ram.size  = use_dp ? dp_size : i_hsize;

  assign o_idle = !act && !wr_pend;

  assign off = dp_addr[1:0];

  always_comb
  begin
    ram.wdata = i_hwdata;
    o_hrdata  = ram.rdata;
    if (!i_big_endian_b)
    begin
      ram.wdata = '0;
      o_hrdata  = '0;
      case (dp_size)
        sms_pkg::SIZE_BYTE:
        begin
          ram.wdata[{off, 3'b000} +: 8] = i_hwdata[{~off, 3'b000} +: 8];
          o_hrdata[{~off, 3'b000} +: 8] = ram.rdata[{off, 3'b000} +: 8];
        end
        sms_pkg::SIZE_HALF:
        begin
          ram.wdata[{off[1], 4'b0000} +: 16] = i_hwdata[{~off[1], 4'b0000} +: 16];
          o_hrdata[{~off[1], 4'b0000} +: 16] = ram.rdata[{off[1], 4'b0000} +: 16];
        end
        sms_pkg::SIZE_WORD:
        begin
          ram.wdata = i_hwdata;
          o_hrdata  = ram.rdata;
        end
        default: ;
      endcase
    end
  end

  // Stall never lasts two cycles
  a_raw_single : assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    raw_flag |=> !raw_flag
  );

endmodule

// ==== rtl/sms_region_guard.sv ====
// Blocks AHB transfers that hit a denied direction and answers them with the
// two-cycle ERROR response. Other transfers pass through to the slave.

`timescale 1ns/1ps

module sms_region_guard (
  input  logic             i_sys_hclk,
  input  logic             i_sys_rst_b,
  input  logic             i_hsel,
  input  sms_pkg::htrans_t i_htrans,
  input  logic             i_hwrite,
  input  logic             i_rd_deny,
  input  logic             i_wr_deny,
  output logic             o_hready,
  output sms_pkg::hresp_t  o_hresp,
  sms_ahb_if.guard         bus
);

  logic act;
  logic deny;
  logic err_wait;  // First ERROR cycle with ready low
  logic err_done;  // Second ERROR cycle with ready high

  assign act  = i_hsel && o_hready &&
                (i_htrans == sms_pkg::TRANS_NONSEQ || i_htrans == sms_pkg::TRANS_SEQ);
  assign deny = act && (i_hwrite ? i_wr_deny : i_rd_deny);

  // The slave sees IDLE for a denied transfer and during the wait cycle
  assign bus.sel   = (deny || err_wait) ? 1'b0 : i_hsel;
  assign bus.trans = (deny || err_wait) ? '0 : i_htrans;

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      err_wait <= 1'b0;
      err_done <= 1'b0;
    end
    else
    begin
      err_wait <= deny;
      err_done <= err_wait;
    end
  end

  assign o_hready = err_wait ? 1'b0 : (err_done ? 1'b1 : bus.ready);
  assign o_hresp  = (err_wait || err_done) ? sms_pkg::RESP_ERROR : bus.resp;

  // Wait-then-ready ERROR and no third ERROR cycle
  a_err_two_cycles : assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    deny |=> (!o_hready && o_hresp == sms_pkg::RESP_ERROR)
             ##1 (o_hready && o_hresp == sms_pkg::RESP_ERROR && !err_wait)
             ##1 !err_done
  );

endmodule

// ==== rtl/sms_ahb_if.sv ====
// Filtered AHB select and transfer type from the region guard to the slave,
// with the slave's ready and response returned to the guard.

`timescale 1ns/1ps

interface sms_ahb_if;

  logic             sel;
  sms_pkg::htrans_t trans;
  logic             ready;
  sms_pkg::hresp_t  resp;

  modport guard (
    output sel,
    output trans,
    input  ready,
    input  resp
  );

  modport slave (
    input  sel,
    input  trans,
    output ready,
    output resp
  );

endinterface

// ==== rtl/sms_ram_if.sv ====
// RAM request and read data path between the AHB slave and the SRAM bank.
// A request acts in any cycle where sel is high, with no other handshake.

`timescale 1ns/1ps

interface sms_ram_if;

  logic                       sel;
  logic                       write;
  sms_pkg::hsize_t            size;
  logic [sms_pkg::ADDR_W-1:0] addr;   // Byte offset inside the bank
  logic [sms_pkg::DATA_W-1:0] wdata;
  logic [sms_pkg::DATA_W-1:0] rdata;  // One cycle after the request

  modport master (
    output sel,
    output write,
    output size,
    output addr,
    output wdata,
    input  rdata
  );

  modport ram (
    input  sel,
    input  write,
    input  size,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== rtl/sms_pkg.sv ====
// Widths, AHB encodings and small types shared by the SRAM bank RTL.
// Referenced by scoped name from every file that needs them.

package sms_pkg;

  localparam int DATA_W      = 32;
  localparam int BYTES_W     = DATA_W / 8;
  localparam int ADDR_W      = 16;               // 64 KiB bank offset
  localparam int WORD_ADDR_W = ADDR_W - 2;       // Word index into the array
  localparam int RAM_DEPTH   = 1 << WORD_ADDR_W;

  typedef logic [1:0]         htrans_t;
  typedef logic [2:0]         hsize_t;
  typedef logic [1:0]         hresp_t;
  typedef logic [BYTES_W-1:0] lane_mask_t;

  // AHB transfer types that start a data phase
  localparam htrans_t TRANS_NONSEQ = 2'b10;
  localparam htrans_t TRANS_SEQ    = 2'b11;

  localparam hsize_t SIZE_BYTE = 3'b000;
  localparam hsize_t SIZE_HALF = 3'b001;
  localparam hsize_t SIZE_WORD = 3'b010;

  localparam hresp_t RESP_OKAY  = 2'b00;
  localparam hresp_t RESP_ERROR = 2'b01;

endpackage
